// ==== logic/board_init_pkg.sv ====
`default_nettype none

package board_init_pkg;

	// host register port
	typedef logic [3:0]  host_addr_t;	// register index
	typedef logic [31:0] host_word_t;	// register data

	typedef struct packed {
		logic       we;	// 1 = write, 0 = read
		host_addr_t addr;
		host_word_t wdata;	// ignored on reads
	} host_req_t;	// 37 bits

	// register map
	localparam host_addr_t ADDR_CHAIN   = 4'd0;	// error/done bits of the chain
	localparam host_addr_t ADDR_LINK    = 4'd1;	// link up + reconnect counts
	localparam host_addr_t ADDR_CTRL    = 4'd2;	// bit 0 restarts the chain
	localparam host_addr_t ADDR_SCRATCH = 4'd3;	// free r/w word

	// serial links on the board
	localparam int LINK_COUNT = 2;

	typedef logic [7:0] los_cnt_t;	// saturating reconnect count

	typedef struct packed {
		logic [LINK_COUNT-1:0]     link_up;	// one bit per link
		los_cnt_t [LINK_COUNT-1:0] reconnects;	// link 1 in the upper byte
	} link_status_t;	// 18 bits

	// reset chain sequencer
	typedef enum logic [2:0] {
		st_idle,	// nothing started yet
		st_hold,	// reset of current step held
		st_wait,	// waiting for done of current step
		st_done,	// all steps finished
		st_fail	// a step timed out
	} step_state_e;

	// host handshake
	typedef enum logic {
		ps_idle,	// waiting for req
		ps_ack	// ack high until req drops
	} port_state_e;

endpackage

`default_nettype wire

// ==== logic/por_gen.sv ====
`default_nettype none

module por_gen #(
	parameter int POR_LEN = 20	// cycles from reset release to pulse
) (
	input  wire  clk200,
	input  wire  arst_n,
	output logic por_pulse	// one cycle wide
);

	localparam int CW = $clog2(POR_LEN + 1);	// counter width

	logic [CW-1:0] cnt;	// cycles since release
	logic          por_r;	// terminal flag, sticky
	logic          por_d;	// delayed copy for edge detect

	always_ff @(posedge clk200 or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= '0;
			por_r <= 1'b0;
			por_d <= 1'b0;
		end else begin
			if (!por_r)
				cnt <= cnt + 1'b1;	// freezes once flag is up
			if (!por_r && cnt == CW'(POR_LEN - 1))
				por_r <= 1'b1;	// set on edge POR_LEN
			por_d <= por_r;
		end
	end

	assign por_pulse = por_r & ~por_d;	// rising edge of the flag

endmodule

`default_nettype wire

// ==== logic/reset_chain.sv ====
`default_nettype none

module reset_chain #(
	parameter int NSTEP        = 4,	// 1 to 16 steps
	parameter int RESET_LEN    = 10,	// hold cycles per step
	parameter int STEP_TIMEOUT = 200	// max wait cycles for done
) (
	input  wire              clk200,
	input  wire              arst_n,
	input  wire              por_pulse,	// power-on start
	input  wire              restart,	// host start
	input  wire  [NSTEP-1:0] done_in,	// async from peripherals
	output logic [NSTEP-1:0] reset_out,	// one step at a time
	output logic [NSTEP-1:0] step_done,
	output logic [NSTEP-1:0] step_error
);

	import board_init_pkg::*;

	localparam int IW      = (NSTEP > 1) ? $clog2(NSTEP) : 1;	// step index width
	localparam int CNT_MAX = (RESET_LEN > STEP_TIMEOUT) ? RESET_LEN : STEP_TIMEOUT;
	localparam int CW      = $clog2(CNT_MAX + 1);	// shared counter width

	step_state_e   state;
	logic [IW-1:0] idx;	// current step
	logic [CW-1:0] cnt;	// hold time or timeout by state
	logic [NSTEP-1:0] done_s1;	// sync stage 1
	logic [NSTEP-1:0] done_s2;	// sync stage 2
	logic start;

	assign start = por_pulse | restart;	// either pulse (re)starts

	// two-stage synchronizer on done
	always_ff @(posedge clk200 or negedge arst_n) begin
		if (!arst_n) begin
			done_s1 <= '0;
			done_s2 <= '0;
		end else begin
			done_s1 <= done_in;
			done_s2 <= done_s1;
		end
	end

	always_ff @(posedge clk200 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			idx        <= '0;
			cnt        <= '0;
			step_done  <= '0;
			step_error <= '0;
		end else if (start) begin
			state      <= st_hold;	// reset_out[0] from next cycle
			idx        <= '0;
			cnt        <= '0;
			step_done  <= '0;	// clear old results
			step_error <= '0;
		end else begin
			case (state)
				st_hold: begin
					if (cnt == CW'(RESET_LEN - 1)) begin
						state <= st_wait;	// RESET_LEN cycles held
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_wait: begin
					if (done_s2[idx]) begin
						step_done[idx] <= 1'b1;
						cnt            <= '0;
						if (idx == IW'(NSTEP - 1)) begin
							state <= st_done;	// last step finished
						end else begin
							idx   <= idx + 1'b1;
							state <= st_hold;	// next reset on the following cycle
						end
					end else if (cnt == CW'(STEP_TIMEOUT - 1)) begin
						step_error[idx] <= 1'b1;
						state           <= st_fail;	// chain halts here
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					cnt <= '0;	// idle, done and fail wait for start
				end
			endcase
		end
	end

	// decode held reset from state and index
	always_comb begin
		reset_out = '0;
		if (state == st_hold)
			reset_out[idx] = 1'b1;
	end

	// only the step right after the finished ones may be held
	a_reset_next_step: assert property (@(posedge clk200) disable iff (!arst_n)
		reset_out == '0 || reset_out == NSTEP'(step_done + 1'b1));

	// a finished step never also reports a timeout
	a_done_xor_error: assert property (@(posedge clk200) disable iff (!arst_n)
		(step_done & step_error) == '0);

endmodule

`default_nettype wire

// ==== logic/link_monitor.sv ====
`default_nettype none

module link_monitor (
	input  wire                                clk200,
	input  wire                                arst_n,
	input  wire  [board_init_pkg::LINK_COUNT-1:0] los_in,	// async loss of signal
	output board_init_pkg::link_status_t       link_status
);

	import board_init_pkg::*;

	logic [LINK_COUNT-1:0]     los_s1;	// sync stage 1
	logic [LINK_COUNT-1:0]     los_s2;	// sync stage 2
	logic [LINK_COUNT-1:0]     los_q;	// previous synced los
	logic [LINK_COUNT-1:0]     link_up_q;	// third stage, inverted
	logic [LINK_COUNT-1:0]     reconn;	// los falling edge
	los_cnt_t [LINK_COUNT-1:0] rc_cnt;	// reconnects per link

	assign reconn = los_q & ~los_s2;	// signal came back

	always_ff @(posedge clk200 or negedge arst_n) begin
		if (!arst_n) begin
			los_s1    <= '0;
			los_s2    <= '0;
			los_q     <= '0;	// no edge counted out of reset
			link_up_q <= '0;
			rc_cnt    <= '0;
		end else begin
			los_s1    <= los_in;
			los_s2    <= los_s1;
			los_q     <= los_s2;
			link_up_q <= ~los_s2;	// three cycles behind los_in
			for (int i = 0; i < LINK_COUNT; i++) begin
				if (reconn[i] && rc_cnt[i] != '1)
					rc_cnt[i] <= rc_cnt[i] + 1'b1;	// sticks at 255
			end
		end
	end

	assign link_status.link_up    = link_up_q;
	assign link_status.reconnects = rc_cnt;

	// saturation holds across cycles, per link
	for (genvar g = 0; g < LINK_COUNT; g++) begin : g_sat_chk
		a_no_wrap: assert property (@(posedge clk200) disable iff (!arst_n)
			rc_cnt[g] == '1 |=> rc_cnt[g] != '0);
	end

endmodule

`default_nettype wire

// ==== logic/status_regs.sv ====
`default_nettype none

module status_regs #(
	parameter int NSTEP = 4	// width of the chain status
) (
	input  wire                          clk200,
	input  wire                          arst_n,
	input  wire                          host_req_valid,	// four-phase req
	input  board_init_pkg::host_req_t    host_req,
	output logic                         host_ack,
	output board_init_pkg::host_word_t   host_rdata,	// valid while ack high
	input  wire  [NSTEP-1:0]             step_done,
	input  wire  [NSTEP-1:0]             step_error,
	input  board_init_pkg::link_status_t link_status,
	output logic                         restart	// one-cycle pulse to chain
);

	import board_init_pkg::*;

	port_state_e state;
	logic        access;	// req seen in idle
	host_word_t  scratch;	// host scratch word
	host_word_t  rd_mux;	// read data of addressed reg
	host_word_t  rdata_q;	// held for the ack phase

	assign access = (state == ps_idle) && host_req_valid;

	// read side
	always_comb begin
		case (host_req.addr)
			ADDR_CHAIN:   rd_mux = {16'(step_error), 16'(step_done)};
			ADDR_LINK:    rd_mux = host_word_t'({link_status.link_up, link_status.reconnects});
			ADDR_SCRATCH: rd_mux = scratch;
			default:      rd_mux = '0;	// ctrl and unmapped read zero
		endcase
	end

	// handshake fsm, write side, restart strobe
	always_ff @(posedge clk200 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ps_idle;
			scratch <= '0;
			restart <= 1'b0;
		end else begin
			restart <= 1'b0;	// default low
			case (state)
				ps_idle: begin
					if (access) begin
						state <= ps_ack;	// ack from next cycle
						if (host_req.we && host_req.addr == ADDR_SCRATCH)
							scratch <= host_req.wdata;
						if (host_req.we && host_req.addr == ADDR_CTRL && host_req.wdata[0])
							restart <= 1'b1;
					end
				end
				ps_ack: begin
					if (!host_req_valid)
						state <= ps_idle;	// ack drops one cycle after req
				end
				default: state <= ps_idle;
			endcase
		end
	end

	// capture read data with the access
	always_ff @(posedge clk200) begin
		if (access)
			rdata_q <= rd_mux;
	end

	assign host_ack   = (state == ps_ack);
	assign host_rdata = rdata_q;

	// ack only answers a req seen the cycle before
	a_ack_needs_req: assert property (@(posedge clk200) disable iff (!arst_n)
		$rose(host_ack) |-> $past(host_req_valid));

	// restart is a single-cycle strobe
	a_restart_pulse: assert property (@(posedge clk200) disable iff (!arst_n)
		restart |=> !restart);

endmodule

`default_nettype wire

// ==== logic/board_init_top.sv ====
`default_nettype none

module board_init_top #(
	parameter int NSTEP        = 4,	// reset steps
	parameter int RESET_LEN    = 10,	// hold cycles per step
	parameter int STEP_TIMEOUT = 200,	// done wait limit
	parameter int POR_LEN      = 20	// power-on delay
) (
	input  wire                                   clk200,
	input  wire                                   arst_n,
	input  wire  [NSTEP-1:0]                      done_in,
	output logic [NSTEP-1:0]                      reset_out,
	input  wire  [board_init_pkg::LINK_COUNT-1:0] los_in,
	input  wire                                   host_req_valid,
	input  board_init_pkg::host_req_t             host_req,
	output logic                                  host_ack,
	output board_init_pkg::host_word_t            host_rdata
);

	import board_init_pkg::*;

	logic             por_pulse;	// power-on start
	logic             restart;	// host start
	logic [NSTEP-1:0] step_done;
	logic [NSTEP-1:0] step_error;
	link_status_t     link_status;

	por_gen #(
		.POR_LEN (POR_LEN)
	) i_por_gen (
		.clk200    (clk200),
		.arst_n    (arst_n),
		.por_pulse (por_pulse)
	);

	reset_chain #(
		.NSTEP        (NSTEP),
		.RESET_LEN    (RESET_LEN),
		.STEP_TIMEOUT (STEP_TIMEOUT)
	) i_reset_chain (
		.clk200     (clk200),
		.arst_n     (arst_n),
		.por_pulse  (por_pulse),
		.restart    (restart),
		.done_in    (done_in),
		.reset_out  (reset_out),
		.step_done  (step_done),
		.step_error (step_error)
	);

	link_monitor i_link_monitor (
		.clk200      (clk200),
		.arst_n      (arst_n),
		.los_in      (los_in),
		.link_status (link_status)
	);

	status_regs #(
		.NSTEP (NSTEP)
	) i_status_regs (
		.clk200         (clk200),
		.arst_n         (arst_n),
		.host_req_valid (host_req_valid),
		.host_req       (host_req),
		.host_ack       (host_ack),
		.host_rdata     (host_rdata),
		.step_done      (step_done),
		.step_error     (step_error),
		.link_status    (link_status),
		.restart        (restart)
	);

endmodule

`default_nettype wire

// ==== verif/board_init_tb.sv ====
`default_nettype none

module board_init_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import board_init_pkg::*;

	localparam int    NSTEP        = 4;
	localparam int    RESET_LEN    = 10;
	localparam int    STEP_TIMEOUT = 200;
	localparam int    POR_LEN      = 20;
	localparam int    RUN_BUDGET   = NSTEP * (RESET_LEN + STEP_TIMEOUT + 40);	// per chain run
	localparam string STIM_FILE    = "verif/board_init_stim.txt";

	logic                  clk200;
	logic                  arst_n;
	logic [NSTEP-1:0]      done_in;
	logic [NSTEP-1:0]      reset_out;
	logic [LINK_COUNT-1:0] los_in;
	logic                  host_req_valid;
	host_req_t             host_req;
	logic                  host_ack;
	host_word_t            host_rdata;

	logic [NSTEP-1:0] model_en;	// peripherals that answer
	logic [NSTEP-1:0] rst_q;	// reset_out one cycle back
	logic [NSTEP-1:0] rst_seen;	// steps held since last P op
	int               resp_cnt [NSTEP];	// cycles left until done
	int               hold_cnt [NSTEP];	// length of current reset pulse
	logic             ack_q;
	int               cycle_cnt;
	int               cycle_limit;
	int               err_cnt;	// whole run
	int               test_err;	// running test only
	int               pass_cnt;
	int               fail_cnt;

	always #5 clk200 = ~clk200;	// 100 MHz stand-in

	board_init_top #(
		.NSTEP        (NSTEP),
		.RESET_LEN    (RESET_LEN),
		.STEP_TIMEOUT (STEP_TIMEOUT),
		.POR_LEN      (POR_LEN)
	) i_dut (
		.clk200         (clk200),
		.arst_n         (arst_n),
		.done_in        (done_in),
		.reset_out      (reset_out),
		.los_in         (los_in),
		.host_req_valid (host_req_valid),
		.host_req       (host_req),
		.host_ack       (host_ack),
		.host_rdata     (host_rdata)
	);

	task automatic note_error();
		err_cnt++;
		test_err++;
	endtask

	// peripheral models, done 5 to 40 cycles after reset falls
	always @(posedge clk200) begin
		rst_q <= reset_out;
		for (int i = 0; i < NSTEP; i++) begin
			if (!arst_n || reset_out[i]) begin
				done_in[i]  <= 1'b0;	// held peripheral not done
				resp_cnt[i] <= 0;
			end else if (rst_q[i] && model_en[i]) begin
				resp_cnt[i] <= 5 + int'($urandom % 36);	// reset just released
			end else if (resp_cnt[i] == 1) begin
				done_in[i]  <= 1'b1;
				resp_cnt[i] <= 0;
			end else if (resp_cnt[i] > 1) begin
				resp_cnt[i] <= resp_cnt[i] - 1;
			end
		end
	end

	// order, hold length and ack checks, sampled mid-cycle
	always @(negedge clk200) begin
		if (arst_n) begin
			if (!$onehot0(reset_out)) begin
				$display("Fail %0t reset_out expected one-hot or zero got %b", $time, reset_out);
				note_error();
			end
			for (int i = 0; i < NSTEP; i++) begin
				if (reset_out[i]) begin
					rst_seen[i] = 1'b1;
					hold_cnt[i] = hold_cnt[i] + 1;
					if (!rst_q[i] && i > 0 && !done_in[i-1]) begin
						$display("step %0d reset rose before step %0d was done", i, i - 1);
						note_error();
					end
				end else if (rst_q[i]) begin
					if (hold_cnt[i] < RESET_LEN) begin
						$display("Fail %0t reset_out[%0d] hold expected %0d got %0d",
							$time, i, RESET_LEN, hold_cnt[i]);
						note_error();
					end
					hold_cnt[i] = 0;	// pulse ended
				end
			end
			if (host_ack && !ack_q && !host_req_valid) begin
				$display("host_ack rose at %0t while req was low", $time);
				note_error();
			end
			ack_q = host_ack;
		end
	end

	// four-phase access, ack timing checked on the way
	task automatic host_access(input logic we, input host_addr_t addr,
		input host_word_t wdata, output host_word_t rdata);
		@(posedge clk200);
		host_req       <= '{we: we, addr: addr, wdata: wdata};
		host_req_valid <= 1'b1;
		@(negedge clk200);
		if (host_ack !== 1'b0) begin
			$display("Fail %0t host_ack expected 0 got %b", $time, host_ack);	// req not sampled yet
			note_error();
		end
		@(negedge clk200);
		if (host_ack !== 1'b1) begin
			$display("Fail %0t host_ack expected 1 got %b", $time, host_ack);
			note_error();
		end
		rdata = host_rdata;
		@(posedge clk200);
		host_req_valid <= 1'b0;
		@(negedge clk200);
		if (host_ack !== 1'b1) begin
			$display("Fail %0t host_ack expected 1 got %b", $time, host_ack);	// drop not sampled
			note_error();
		end
		@(negedge clk200);
		if (host_ack !== 1'b0) begin
			$display("Fail %0t host_ack expected 0 got %b", $time, host_ack);
			note_error();
		end
	endtask

	// poll the chain register until last step done or any error
	task automatic wait_chain_idle();
		host_word_t rd;
		int         polls;
		polls = 0;
		do begin
			host_access(1'b0, ADDR_CHAIN, '0, rd);
			polls++;
		end while (!rd[NSTEP-1] && rd[31:16] == 16'd0 && polls * 4 < RUN_BUDGET);
		if (!rd[NSTEP-1] && rd[31:16] == 16'd0) begin
			$display("chain reached neither done nor fail within %0d cycles", RUN_BUDGET);
			note_error();
		end
	endtask

	// cycle limit from the waits and chain runs in the stim file
	function automatic int stim_budget();
		int    fd;
		int    arg0;
		int    arg1;
		int    total;
		string line;
		string op;
		total = POR_LEN + 3;
		fd    = $fopen(STIM_FILE, "r");
		if (fd == 0)
			return 0;
		while ($fgets(line, fd)) begin
			op   = "";
			arg0 = 0;
			arg1 = 0;
			void'($sscanf(line, "%s %h %h", op, arg0, arg1));
			if (op == "W")
				total += arg0;
			else if (op == "L")
				total += arg1;	// hold after los change
			else if (op == "C")
				total += RUN_BUDGET;
		end
		$fclose(fd);
		return 2 * total;	// margin
	endfunction

	always @(posedge clk200) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout, run still busy after %0d cycles", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	// stim interpreter
	initial begin
		int         fd;
		int         arg0;
		int         arg1;
		string      line;
		string      op;
		string      name;
		host_word_t rd;
		void'($urandom(61955));
		clk200         = 1'b0;
		arst_n         = 1'b0;
		done_in        = '0;
		los_in         = '0;
		host_req_valid = 1'b0;
		host_req       = '0;
		model_en       = '1;
		rst_seen       = '0;
		ack_q          = 1'b0;
		cycle_cnt      = 0;
		err_cnt        = 0;
		test_err       = 0;
		pass_cnt       = 0;
		fail_cnt       = 0;
		foreach (hold_cnt[i])
			hold_cnt[i] = 0;
		cycle_limit = stim_budget();
		repeat (3) @(posedge clk200);
		arst_n <= 1'b1;	// por pulse follows POR_LEN later
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stim file %s", STIM_FILE);
			$display("Regression failed");
			$finish;
		end else begin
			while ($fgets(line, fd)) begin
				op   = "";
				arg0 = 0;
				arg1 = 0;
				void'($sscanf(line, "%s %h %h", op, arg0, arg1));
				if (op != "" && op.substr(0, 0) != "#") begin
					case (op)
						"W": repeat (arg0) @(posedge clk200);
						"D": model_en <= NSTEP'(arg0);
						"L": begin
							@(posedge clk200);
							los_in <= LINK_COUNT'(arg0);
							repeat (arg1) @(posedge clk200);
						end
						"H": host_access(1'b1, host_addr_t'(arg0), host_word_t'(arg1), rd);
						"R": begin
							host_access(1'b0, host_addr_t'(arg0), '0, rd);
							if (rd !== host_word_t'(arg1)) begin
								$display("Fail %0t host_rdata (addr %0h) expected %h got %h",
									$time, arg0, host_word_t'(arg1), rd);
								note_error();
							end
						end
						"C": wait_chain_idle();
						"P": begin
							@(posedge clk200);
							if (rst_seen !== NSTEP'(arg0)) begin
								$display("Fail %0t reset_out seen mask expected %b got %b",
									$time, NSTEP'(arg0), rst_seen);
								note_error();
							end
							rst_seen = '0;
						end
						"T": begin
							@(posedge clk200);
							void'($sscanf(line, "%s %s", op, name));
							if (test_err == 0) begin
								pass_cnt++;
								$display("test %s: ok", name);
							end else begin
								fail_cnt++;
								$display("test %s: FAILED with %0d errors", name, test_err);
							end
							test_err = 0;
						end
						default: begin
							$display("unknown stim op %s", op);
							note_error();
						end
					endcase
				end
			end
			$fclose(fd);
			$display("tests: %0d ok, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
			if (err_cnt == 0 && fail_cnt == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verif/board_init_stim.txt ====
# op and hex args: W cycles | D done_mask | L los hold | H addr data | R addr expect
# C wait chain done or fail | P reset_seen_mask | T test_name
D f
C
R 0 0000000f
P f
T power_on
D b
H 2 00000001
C
R 0 00040003
P 7
T timeout
D f
H 2 00000001
C
R 0 0000000f
P f
T restart
L 1 6
L 0 6
L 3 6
L 0 6
L 1 6
L 0 6
L 2 6
R 1 00010103
T link_monitor
H 3 a5c3e1f0
R 3 a5c3e1f0
H 3 0000beef
R 3 0000beef
R 9 00000000
R 2 00000000
W 10
T handshake_scratch

// ==== board_init.f ====
logic/board_init_pkg.sv
logic/por_gen.sv
logic/reset_chain.sv
logic/link_monitor.sv
logic/status_regs.sv
logic/board_init_top.sv
verif/board_init_tb.sv
